// ==== design/lc3b_pkg.sv ====
package lc3b_pkg;

	// -------------------------------------------------------------------------
	// Basic word types.
	// -------------------------------------------------------------------------

	typedef logic [15:0] lc3b_word;            // Data or byte address.
	typedef logic [2:0]  lc3b_reg;             // Register number.
	typedef logic [1:0]  lc3b_mask;            // Bit 1 selects the high byte.

	localparam int RAM_ADDR_BITS = 8;          // Word index width, 256 words.

	// Memory operation carried by each instruction in the pipeline.
	typedef enum logic [2:0] {
		op_none,
		op_ldw,
		op_ldb,
		op_stw,
		op_stb,
		op_ldi,
		op_sti
	} mem_op_e;

	// -------------------------------------------------------------------------
	// Pipeline records.
	// -------------------------------------------------------------------------

	typedef struct packed {
		logic     valid;
		mem_op_e  op;
		lc3b_word pc;
		lc3b_word alu_out;                     // Result or effective address.
		lc3b_word srcb_out;                    // Store data.
		lc3b_reg  dest;
		logic     wb_en;
	} EX_MEM;

	typedef struct packed {
		logic     valid;
		lc3b_word pc;
		lc3b_reg  dest;
		logic     wb_en;
		lc3b_word result;
	} MEM_WB;

	// Wishbone classic, master side then slave side.
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		lc3b_word adr;
		lc3b_word dat;
		lc3b_mask sel;
	} wb_req_t;

	typedef struct packed {
		lc3b_word dat;
		logic     ack;
	} wb_rsp_t;

endpackage : lc3b_pkg

// ==== design/bus_sequencer.sv ====
module bus_sequencer (
	input  logic              clk,
	input  logic              rst_n,
	input  lc3b_pkg::mem_op_e op,
	input  logic              valid,
	input  logic              ack,
	output logic              busy,
	output logic              ptr_phase,
	output logic              load_ptr,
	output logic              final_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_pointer,
		st_final
	} seq_state_e;

	seq_state_e state;
	seq_state_e state_next;
	logic       is_mem_op;
	logic       is_indirect;

	assign is_mem_op   = (op != lc3b_pkg::op_none);
	assign is_indirect = (op == lc3b_pkg::op_ldi) || (op == lc3b_pkg::op_sti);

	// -------------------------------------------------------------------------
	// Phase sequencing. Each access holds until its acknowledge.
	// -------------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (valid && is_mem_op) begin
					state_next = is_indirect ? st_pointer : st_access;
				end
			end
			st_access: begin
				if (ack) state_next = st_idle;
			end
			st_pointer: begin
				if (ack) state_next = st_final;   // Second stb follows at once.
			end
			st_final: begin
				if (ack) state_next = st_idle;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	assign busy      = (state != st_idle);      // Drives cyc and stb.
	assign ptr_phase = (state == st_pointer);
	assign load_ptr  = ptr_phase && ack;        // Read data holds the pointer here.
	assign final_ack = ack && ((state == st_access) || (state == st_final));

endmodule : bus_sequencer

// ==== design/mem_stage.sv ====
module mem_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  lc3b_pkg::EX_MEM   ex_mem,
	input  lc3b_pkg::wb_rsp_t wb_rsp,
	output lc3b_pkg::wb_req_t wb_req,
	output logic              ex_ready,
	output lc3b_pkg::MEM_WB   mem_wb
);

	logic               busy;
	logic               ptr_phase;
	logic               load_ptr;
	logic               final_ack;
	logic               consume;
	logic               is_byte;
	logic               is_store;
	logic               is_load;
	logic               is_indirect;
	lc3b_pkg::lc3b_word ptr;
	lc3b_pkg::lc3b_word addr;
	lc3b_pkg::lc3b_word load_data;
	lc3b_pkg::MEM_WB    mem_wb_d;
	lc3b_pkg::MEM_WB    payload_q;
	logic               valid_q;

	bus_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.op        (ex_mem.op),
		.valid     (ex_mem.valid),
		.ack       (wb_rsp.ack),
		.busy      (busy),
		.ptr_phase (ptr_phase),
		.load_ptr  (load_ptr),
		.final_ack (final_ack)
	);

	// Operation decode.
	assign is_byte     = (ex_mem.op == lc3b_pkg::op_ldb) || (ex_mem.op == lc3b_pkg::op_stb);
	assign is_indirect = (ex_mem.op == lc3b_pkg::op_ldi) || (ex_mem.op == lc3b_pkg::op_sti);
	assign is_store    = (ex_mem.op == lc3b_pkg::op_stw) || (ex_mem.op == lc3b_pkg::op_stb) ||
	                     (ex_mem.op == lc3b_pkg::op_sti);
	assign is_load     = (ex_mem.op == lc3b_pkg::op_ldw) || (ex_mem.op == lc3b_pkg::op_ldb) ||
	                     (ex_mem.op == lc3b_pkg::op_ldi);

	// -------------------------------------------------------------------------
	// Address path and bus request.
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (load_ptr) ptr <= wb_rsp.dat;          // Pointer word from the first read.
	end

	assign addr = (is_indirect && !ptr_phase) ? ptr : ex_mem.alu_out;

	always_comb begin
		wb_req.cyc = busy;
		wb_req.stb = busy;
		wb_req.we  = busy && is_store && !ptr_phase; // The pointer read never writes.
		wb_req.adr = {addr[15:1], is_byte ? addr[0] : 1'b0};
		wb_req.dat = is_byte ? {2{ex_mem.srcb_out[7:0]}} : ex_mem.srcb_out;
		if (is_byte) begin
			wb_req.sel = addr[0] ? 2'b10 : 2'b01; // One lane for byte stores.
		end else begin
			wb_req.sel = 2'b11;
		end
	end

	// -------------------------------------------------------------------------
	// Load formatting and handshake.
	// -------------------------------------------------------------------------

	// Byte loads pick a lane by address bit 0 and zero-extend.
	assign load_data = is_byte ?
		{8'h00, ex_mem.alu_out[0] ? wb_rsp.dat[15:8] : wb_rsp.dat[7:0]} : wb_rsp.dat;

	assign ex_ready = final_ack || (ex_mem.valid && (ex_mem.op == lc3b_pkg::op_none));
	assign consume  = ex_mem.valid && ex_ready;

	always_comb begin
		mem_wb_d        = '0;
		mem_wb_d.valid  = 1'b1;
		mem_wb_d.pc     = ex_mem.pc;
		mem_wb_d.dest   = ex_mem.dest;
		mem_wb_d.wb_en  = ex_mem.wb_en && !is_store; // Stores write no register.
		mem_wb_d.result = is_load ? load_data : ex_mem.alu_out;
	end

	// -------------------------------------------------------------------------
	// MEM_WB register.
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= consume;                   // High for one cycle per record.
		end
	end

	always_ff @(posedge clk) begin
		if (consume) payload_q <= mem_wb_d;
	end

	always_comb begin
		mem_wb       = payload_q;
		mem_wb.valid = valid_q;
	end

endmodule : mem_stage

// ==== design/data_ram.sv ====
module data_ram (
	input  logic              clk,
	input  logic              rst_n,
	input  lc3b_pkg::wb_req_t wb_req,
	output lc3b_pkg::wb_rsp_t wb_rsp
);

	lc3b_pkg::lc3b_word mem [1 << lc3b_pkg::RAM_ADDR_BITS] = '{default: '0};

	logic [lc3b_pkg::RAM_ADDR_BITS-1:0] idx;
	logic                               req;
	logic                               ack_q;
	lc3b_pkg::lc3b_word                 dat_q;

	// Word index, the byte address taken modulo the array size.
	assign idx = wb_req.adr[lc3b_pkg::RAM_ADDR_BITS:1];
	assign req = wb_req.cyc && wb_req.stb;

	// -------------------------------------------------------------------------
	// Acknowledge, one cycle after stb is first seen.
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req && !ack_q;               // Single-cycle pulse per access.
		end
	end

	// Read data is captured together with ack.
	always_ff @(posedge clk) begin
		if (req && !ack_q) begin
			dat_q <= mem[idx];
		end
	end

	// Writes land on the acknowledge edge.
	always_ff @(posedge clk) begin
		if (req && wb_req.we && ack_q) begin
			if (wb_req.sel[0]) mem[idx][7:0]  <= wb_req.dat[7:0];
			if (wb_req.sel[1]) mem[idx][15:8] <= wb_req.dat[15:8];
		end
	end

	assign wb_rsp.dat = dat_q;
	assign wb_rsp.ack = ack_q;

endmodule : data_ram

// ==== design/lc3b_mem_top.sv ====
module lc3b_mem_top (
	input  logic            clk,
	input  logic            rst_n,
	input  lc3b_pkg::EX_MEM ex_mem,
	output logic            ex_ready,
	output lc3b_pkg::MEM_WB mem_wb
);

	// -------------------------------------------------------------------------
	// Internal Wishbone link between the stage and the data memory.
	// -------------------------------------------------------------------------

	lc3b_pkg::wb_req_t wb_req;
	lc3b_pkg::wb_rsp_t wb_rsp;

	mem_stage u_mem_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem   (ex_mem),
		.wb_rsp   (wb_rsp),
		.wb_req   (wb_req),
		.ex_ready (ex_ready),
		.mem_wb   (mem_wb)
	);

	data_ram u_data_ram (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

endmodule : lc3b_mem_top

// ==== bench/tb_lc3b_mem.sv ====
module tb_lc3b_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 20;           // Cycles allowed for any single wait.

	logic               clk;
	logic               rst_n;
	lc3b_pkg::EX_MEM    ex_mem;
	logic               ex_ready;
	lc3b_pkg::MEM_WB    mem_wb;
	lc3b_pkg::lc3b_word ref_mem [1 << lc3b_pkg::RAM_ADDR_BITS];
	logic [31:0]        lfsr_state;
	lc3b_pkg::lc3b_word pc_count;
	int                 last_ready;           // Cycle of ex_ready, counted from presentation.
	int                 last_wb;              // Cycle of mem_wb.valid.

	lc3b_mem_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem   (ex_mem),
		.ex_ready (ex_ready),
		.mem_wb   (mem_wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Helpers: LFSR, reference model index, value check.
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output lc3b_pkg::lc3b_word v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [lc3b_pkg::RAM_ADDR_BITS-1:0] word_index(
			input lc3b_pkg::lc3b_word addr);
		return addr[lc3b_pkg::RAM_ADDR_BITS:1]; // Byte address modulo 512.
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// Presents one record, waits for consumption and the MEM_WB record, and checks it.
	task automatic run_op(input string name, input lc3b_pkg::mem_op_e op,
			input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data,
			input lc3b_pkg::lc3b_reg dest, input logic wb_en);
		lc3b_pkg::EX_MEM    rec;
		lc3b_pkg::lc3b_word word;
		lc3b_pkg::lc3b_word expected;
		logic               is_store;
		int                 cnt;

		rec          = '0;
		rec.valid    = 1'b1;
		rec.op       = op;
		rec.pc       = pc_count;
		rec.alu_out  = addr;
		rec.srcb_out = data;
		rec.dest     = dest;
		rec.wb_en    = wb_en;
		pc_count     = pc_count + 16'd2;
		word         = ref_mem[word_index(addr)];
		is_store     = (op == lc3b_pkg::op_stw) || (op == lc3b_pkg::op_stb) ||
		               (op == lc3b_pkg::op_sti);
		case (op)
			lc3b_pkg::op_ldw: expected = word;
			lc3b_pkg::op_ldb: expected = addr[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
			lc3b_pkg::op_ldi: expected = ref_mem[word_index(word)]; // Word is the pointer.
			default:          expected = addr;
		endcase

		ex_mem = rec;
		#1;
		cnt = 0;
		while (!ex_ready) begin
			if (cnt >= WAIT_LIMIT) begin
				$display("Timeout: ex_ready never rose during %s.", name);
				$display("sim failed");
				$fatal(1);
			end
			@(negedge clk);
			cnt++;
		end
		last_ready = cnt;
		@(negedge clk);                       // The record was consumed on the edge before.
		ex_mem = '0;
		cnt    = last_ready + 1;
		while (!mem_wb.valid) begin
			if (cnt >= last_ready + WAIT_LIMIT) begin
				$display("Timeout: mem_wb.valid never rose during %s.", name);
				$display("sim failed");
				$fatal(1);
			end
			@(negedge clk);
			cnt++;
		end
		last_wb = cnt;

		check({name, " pc"}, rec.pc, mem_wb.pc);
		check({name, " dest"}, 16'(rec.dest), 16'(mem_wb.dest));
		check({name, " wb_en"}, 16'(wb_en && !is_store), 16'(mem_wb.wb_en));
		check({name, " result"}, expected, mem_wb.result);

		// Reference memory follows the same byte select rule as the RAM.
		case (op)
			lc3b_pkg::op_stw: ref_mem[word_index(addr)] = data;
			lc3b_pkg::op_stb: begin
				if (addr[0]) ref_mem[word_index(addr)][15:8] = data[7:0];
				else ref_mem[word_index(addr)][7:0] = data[7:0];
			end
			lc3b_pkg::op_sti: ref_mem[word_index(word)] = data;
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Directed tests.
	// ------------------------------------------------------------------------

	task automatic reset_and_idle();
		rst_n = 1'b0;
		repeat (10) begin
			@(negedge clk);
			check("reset valid", 16'd0, 16'(mem_wb.valid));
			check("reset ready", 16'd0, 16'(ex_ready));
		end
		rst_n = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check("idle valid", 16'd0, 16'(mem_wb.valid));
			check("idle ready", 16'd0, 16'(ex_ready));
		end
	endtask

	task automatic passthrough_record();
		run_op("none", lc3b_pkg::op_none, 16'h1234, 16'hbeef, 3'd5, 1'b1);
		check("none ready cycle", 16'd0, 16'(last_ready));
		check("none wb cycle", 16'd1, 16'(last_wb));
	endtask

	task automatic word_store_load();
		run_op("stw", lc3b_pkg::op_stw, 16'h0064, 16'ha5c3, 3'd2, 1'b1);
		run_op("ldw", lc3b_pkg::op_ldw, 16'h0064, 16'h0000, 3'd3, 1'b1);
		check("ldw data", 16'ha5c3, mem_wb.result);
		check("ldw ready cycle", 16'd2, 16'(last_ready));
		check("ldw wb cycle", 16'd3, 16'(last_wb));
	endtask

	task automatic byte_lanes();
		run_op("stb even", lc3b_pkg::op_stb, 16'h0050, 16'h12ab, 3'd1, 1'b1);
		run_op("ldw low byte", lc3b_pkg::op_ldw, 16'h0050, 16'h0000, 3'd4, 1'b1);
		run_op("stb odd", lc3b_pkg::op_stb, 16'h0051, 16'h34cd, 3'd1, 1'b1);
		run_op("ldb even", lc3b_pkg::op_ldb, 16'h0050, 16'h0000, 3'd4, 1'b1);
		run_op("ldb odd", lc3b_pkg::op_ldb, 16'h0051, 16'h0000, 3'd4, 1'b1);
		run_op("ldw bytes", lc3b_pkg::op_ldw, 16'h0050, 16'h0000, 3'd4, 1'b1);
		check("ldw bytes data", 16'hcdab, mem_wb.result);
	endtask

	task automatic indirect_access();
		run_op("stw pointer", lc3b_pkg::op_stw, 16'h0022, 16'h0140, 3'd0, 1'b0);
		run_op("sti", lc3b_pkg::op_sti, 16'h0022, 16'h5a69, 3'd6, 1'b1);
		run_op("ldi", lc3b_pkg::op_ldi, 16'h0022, 16'h0000, 3'd7, 1'b1);
		check("ldi ready cycle", 16'd4, 16'(last_ready));
		check("ldi wb cycle", 16'd5, 16'(last_wb));
		run_op("ldw target", lc3b_pkg::op_ldw, 16'h0140, 16'h0000, 3'd7, 1'b1);
		check("ldw target data", 16'h5a69, mem_wb.result);
	endtask

	task automatic random_traffic();
		lc3b_pkg::lc3b_word kind;
		lc3b_pkg::lc3b_word addr;
		lc3b_pkg::lc3b_word data;
		lc3b_pkg::lc3b_word misc;
		lc3b_pkg::mem_op_e  op;

		for (int n = 0; n < 60; n++) begin
			take_bits(3, kind);
			take_bits(16, addr);
			take_bits(16, data);
			take_bits(4, misc);               // Destination and write-back enable.
			case (kind[2:0])
				3'd0:    op = lc3b_pkg::op_none;
				3'd2:    op = lc3b_pkg::op_ldb;
				3'd3:    op = lc3b_pkg::op_stw;
				3'd4:    op = lc3b_pkg::op_stb;
				3'd5:    op = lc3b_pkg::op_ldi;
				3'd6:    op = lc3b_pkg::op_sti;
				default: op = lc3b_pkg::op_ldw;
			endcase
			run_op($sformatf("random %0d %s", n, op.name()), op, addr, data, misc[2:0], misc[3]);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		ex_mem     = '0;
		lfsr_state = 32'h9bed_44a6;
		pc_count   = 16'h3000;
		last_ready = 0;
		last_wb    = 0;
		for (int i = 0; i < (1 << lc3b_pkg::RAM_ADDR_BITS); i++) begin
			ref_mem[i] = '0;                  // The RAM starts cleared as well.
		end

		reset_and_idle();
		passthrough_record();
		word_store_load();
		byte_lanes();
		indirect_access();
		random_traffic();

		$display("sim passed");
		$finish;
	end

endmodule : tb_lc3b_mem

// ==== lc3b_mem.f ====
design/lc3b_pkg.sv
design/bus_sequencer.sv
design/mem_stage.sv
design/data_ram.sv
design/lc3b_mem_top.sv
bench/tb_lc3b_mem.sv

// ==== Makefile ====
# Verilator build and run of the LC-3b memory stage testbench.
TOP := tb_lc3b_mem
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module $(TOP) -f lc3b_mem.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported a failure."; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "Simulation ended without a result."; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
